/* flist.f */
logic/ex_pkg.sv
logic/alu.sv
logic/alu_control.sv
logic/forward_unit.sv
logic/ex_stage.sv
logic/writeback_regfile.sv
logic/ex_subsystem.sv
verification/tb_ex_subsystem.sv

/* logic/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire  [ex_pkg::NB_FUNC-1:0]  i_func,
    input  wire  [ex_pkg::NB_DATA-1:0]  i_a,
    input  wire  [ex_pkg::NB_DATA-1:0]  i_b,
    input  wire  [ex_pkg::NB_SHAMT-1:0] i_shamt,
    output logic [ex_pkg::NB_DATA-1:0]  o_result
);

    logic                        lt_signed;
    logic                        lt_unsigned;
    logic [ex_pkg::NB_SHAMT-1:0] var_shamt;

    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    // variable shifts take the amount from rs
    assign var_shamt = i_a[ex_pkg::NB_SHAMT-1:0];

    always_comb begin
        case (i_func)
            // no overflow traps, signed and unsigned add alike
            ex_pkg::FN_ADD,
            ex_pkg::FN_ADDU: begin
                o_result = i_a + i_b;
            end
            ex_pkg::FN_SUB,
            ex_pkg::FN_SUBU: begin
                o_result = i_a - i_b;
            end
            ex_pkg::FN_AND: begin
                o_result = i_a & i_b;
            end
            ex_pkg::FN_OR: begin
                o_result = i_a | i_b;
            end
            ex_pkg::FN_XOR: begin
                o_result = i_a ^ i_b;
            end
            ex_pkg::FN_NOR: begin
                o_result = ~(i_a | i_b);
            end
            ex_pkg::FN_SLT: begin
                o_result = {{(ex_pkg::NB_DATA-1){1'b0}}, lt_signed};
            end
            ex_pkg::FN_SLTU: begin
                o_result = {{(ex_pkg::NB_DATA-1){1'b0}}, lt_unsigned};
            end
            // fixed shifts act on rt
            ex_pkg::FN_SLL: begin
                o_result = i_b << i_shamt;
            end
            ex_pkg::FN_SRL: begin
                o_result = i_b >> i_shamt;
            end
            ex_pkg::FN_SRA: begin
                o_result = $signed(i_b) >>> i_shamt;
            end
            ex_pkg::FN_SLLV: begin
                o_result = i_b << var_shamt;
            end
            ex_pkg::FN_SRLV: begin
                o_result = i_b >> var_shamt;
            end
            ex_pkg::FN_SRAV: begin
                o_result = $signed(i_b) >>> var_shamt;
            end
            ex_pkg::FN_LUI: begin
                o_result = i_b << 16;
            end
            // idle and anything unknown
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/alu_control.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_control (
    input  wire  [ex_pkg::NB_ALU_OP-1:0] i_alu_op,
    input  wire  [ex_pkg::NB_FUNC-1:0]   i_func,
    input  wire  [ex_pkg::NB_FUNC-1:0]   i_opcode,
    output logic [ex_pkg::NB_FUNC-1:0]   o_alu_func
);

    always_comb begin
        case (i_alu_op)
            // address calculation
            ex_pkg::LOAD_STORE: o_alu_func = ex_pkg::FN_ADD;
            ex_pkg::BRANCH:     o_alu_func = ex_pkg::FN_IDLE;
            ex_pkg::R_TYPE:     o_alu_func = i_func;
            ex_pkg::I_TYPE: begin
                // immediate opcode to matching function
                case (i_opcode)
                    ex_pkg::OP_ADDI:  o_alu_func = ex_pkg::FN_ADD;
                    ex_pkg::OP_ADDIU: o_alu_func = ex_pkg::FN_ADDU;
                    ex_pkg::OP_ANDI:  o_alu_func = ex_pkg::FN_AND;
                    ex_pkg::OP_ORI:   o_alu_func = ex_pkg::FN_OR;
                    ex_pkg::OP_XORI:  o_alu_func = ex_pkg::FN_XOR;
                    ex_pkg::OP_SLTI:  o_alu_func = ex_pkg::FN_SLT;
                    ex_pkg::OP_SLTIU: o_alu_func = ex_pkg::FN_SLTU;
                    ex_pkg::OP_LUI:   o_alu_func = ex_pkg::FN_LUI;
                    default:          o_alu_func = ex_pkg::FN_IDLE;
                endcase
            end
            default: begin
                o_alu_func = ex_pkg::FN_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    // datapath widths
    localparam int NB_DATA   = 32;
    localparam int NB_REG    = 5;
    localparam int NB_FUNC   = 6;
    localparam int NB_SHAMT  = 5;
    localparam int NB_ALU_OP = 2;
    localparam int NB_WIDTH  = 2;

    // op classes from decode
    localparam logic [NB_ALU_OP-1:0] LOAD_STORE = 2'b00;
    localparam logic [NB_ALU_OP-1:0] BRANCH     = 2'b01;
    localparam logic [NB_ALU_OP-1:0] R_TYPE     = 2'b10;
    localparam logic [NB_ALU_OP-1:0] I_TYPE     = 2'b11;

    // alu function codes, same values as the mips function field
    localparam logic [NB_FUNC-1:0] FN_SLL  = 6'b000000;
    localparam logic [NB_FUNC-1:0] FN_SRL  = 6'b000010;
    localparam logic [NB_FUNC-1:0] FN_SRA  = 6'b000011;
    localparam logic [NB_FUNC-1:0] FN_SLLV = 6'b000100;
    localparam logic [NB_FUNC-1:0] FN_SRLV = 6'b000110;
    localparam logic [NB_FUNC-1:0] FN_SRAV = 6'b000111;
    localparam logic [NB_FUNC-1:0] FN_ADD  = 6'b100000;
    localparam logic [NB_FUNC-1:0] FN_ADDU = 6'b100001;
    localparam logic [NB_FUNC-1:0] FN_SUB  = 6'b100010;
    localparam logic [NB_FUNC-1:0] FN_SUBU = 6'b100011;
    localparam logic [NB_FUNC-1:0] FN_AND  = 6'b100100;
    localparam logic [NB_FUNC-1:0] FN_OR   = 6'b100101;
    localparam logic [NB_FUNC-1:0] FN_XOR  = 6'b100110;
    localparam logic [NB_FUNC-1:0] FN_NOR  = 6'b100111;
    localparam logic [NB_FUNC-1:0] FN_SLT  = 6'b101010;
    localparam logic [NB_FUNC-1:0] FN_SLTU = 6'b101011;
    // internal only, not real function fields
    localparam logic [NB_FUNC-1:0] FN_LUI  = 6'b111110;
    localparam logic [NB_FUNC-1:0] FN_IDLE = 6'b111111;

    // i-type opcodes
    localparam logic [NB_FUNC-1:0] OP_ADDI  = 6'b001000;
    localparam logic [NB_FUNC-1:0] OP_ADDIU = 6'b001001;
    localparam logic [NB_FUNC-1:0] OP_SLTI  = 6'b001010;
    localparam logic [NB_FUNC-1:0] OP_SLTIU = 6'b001011;
    localparam logic [NB_FUNC-1:0] OP_ANDI  = 6'b001100;
    localparam logic [NB_FUNC-1:0] OP_ORI   = 6'b001101;
    localparam logic [NB_FUNC-1:0] OP_XORI  = 6'b001110;
    localparam logic [NB_FUNC-1:0] OP_LUI   = 6'b001111;

    typedef enum logic [1:0] {
        FWD_REG   = 2'b00,
        FWD_MEMWB = 2'b10,
        FWD_EXMEM = 2'b11
    } fwd_sel_t;

    typedef struct packed {
        logic [NB_REG-1:0]    rs;
        logic [NB_REG-1:0]    rt;
        logic [NB_REG-1:0]    rd;
        logic [NB_DATA-1:0]   immediate;
        logic [NB_FUNC-1:0]   opcode;
        logic [NB_SHAMT-1:0]  shamt;
        logic [NB_FUNC-1:0]   func;
        logic                 reg_dst;
        logic                 mem2reg;
        logic                 mem_read;
        logic                 mem_write;
        logic                 imm_flag;
        logic                 reg_write;
        logic [NB_ALU_OP-1:0] alu_op;
        logic [NB_WIDTH-1:0]  width;
        logic                 sign_flag;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [NB_REG-1:0]   write_reg;
        logic                reg_write;
        logic                mem2reg;
        logic                mem_read;
        logic                mem_write;
        logic [NB_WIDTH-1:0] width;
        logic                sign_flag;
        logic [NB_DATA-1:0]  result;
        logic [NB_DATA-1:0]  data4mem;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic [NB_REG-1:0]  write_reg;
        logic               reg_write;
        logic [NB_DATA-1:0] result;
    } mem_wb_t;

endpackage

`default_nettype wire

/* logic/ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_halt,
    input  wire                        i_valid,
    input  wire  ex_pkg::id_ex_t       i_id_ex,
    input  wire  [ex_pkg::NB_DATA-1:0] i_reg_a,
    input  wire  [ex_pkg::NB_DATA-1:0] i_reg_b,
    input  wire  ex_pkg::fwd_sel_t     i_fw_a,
    input  wire  ex_pkg::fwd_sel_t     i_fw_b,
    input  wire  [ex_pkg::NB_DATA-1:0] i_mem_wb_result,
    output ex_pkg::ex_mem_t            o_ex_mem
);

    logic [ex_pkg::NB_FUNC-1:0]  alu_func;
    logic [ex_pkg::NB_DATA-1:0]  opnd_a;
    logic [ex_pkg::NB_DATA-1:0]  fwd_b;
    logic [ex_pkg::NB_DATA-1:0]  opnd_b;
    logic [ex_pkg::NB_DATA-1:0]  alu_result;
    logic [ex_pkg::NB_REG-1:0]   dest_reg;

    // ex/mem control fields
    logic                        valid_q;
    logic [ex_pkg::NB_REG-1:0]   write_reg_q;
    logic                        reg_write_q;
    logic                        mem2reg_q;
    logic                        mem_read_q;
    logic                        mem_write_q;
    logic [ex_pkg::NB_WIDTH-1:0] width_q;
    logic                        sign_flag_q;
    // ex/mem payload
    logic [ex_pkg::NB_DATA-1:0]  result_q;
    logic [ex_pkg::NB_DATA-1:0]  data4mem_q;

    // operand a, own result wins over mem/wb
    always_comb begin
        case (i_fw_a)
            ex_pkg::FWD_EXMEM: opnd_a = result_q;
            ex_pkg::FWD_MEMWB: opnd_a = i_mem_wb_result;
            default:           opnd_a = i_reg_a;
        endcase
    end

    always_comb begin
        case (i_fw_b)
            ex_pkg::FWD_EXMEM: fwd_b = result_q;
            ex_pkg::FWD_MEMWB: fwd_b = i_mem_wb_result;
            default:           fwd_b = i_reg_b;
        endcase
    end

    // store data is the forwarded rt, taken before the immediate mux
    assign opnd_b   = i_id_ex.imm_flag ? i_id_ex.immediate : fwd_b;
    assign dest_reg = i_id_ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    alu_control u_alu_control (
        .i_alu_op   (i_id_ex.alu_op),
        .i_func     (i_id_ex.func),
        .i_opcode   (i_id_ex.opcode),
        .o_alu_func (alu_func)
    );

    alu u_alu (
        .i_func   (alu_func),
        .i_a      (opnd_a),
        .i_b      (opnd_b),
        .i_shamt  (i_id_ex.shamt),
        .o_result (alu_result)
    );

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q     <= 1'b0;
            write_reg_q <= '0;
            reg_write_q <= 1'b0;
            mem2reg_q   <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            width_q     <= 2'b11;
            sign_flag_q <= 1'b0;
        end else if (!i_halt) begin
            valid_q     <= i_valid;
            write_reg_q <= dest_reg;
            reg_write_q <= i_id_ex.reg_write;
            mem2reg_q   <= i_id_ex.mem2reg;
            mem_read_q  <= i_id_ex.mem_read;
            mem_write_q <= i_id_ex.mem_write;
            width_q     <= i_id_ex.width;
            sign_flag_q <= i_id_ex.sign_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            result_q   <= alu_result;
            data4mem_q <= fwd_b;
        end
    end

    always_comb begin
        o_ex_mem.valid     = valid_q;
        o_ex_mem.write_reg = write_reg_q;
        o_ex_mem.reg_write = reg_write_q;
        o_ex_mem.mem2reg   = mem2reg_q;
        o_ex_mem.mem_read  = mem_read_q;
        o_ex_mem.mem_write = mem_write_q;
        o_ex_mem.width     = width_q;
        o_ex_mem.sign_flag = sign_flag_q;
        o_ex_mem.result    = result_q;
        o_ex_mem.data4mem  = data4mem_q;
    end

endmodule

`default_nettype wire

/* logic/ex_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_subsystem (
    input  wire                  clk,
    input  wire                  i_rst_n,
    input  wire                  i_halt,
    input  wire                  i_valid,
    input  wire  ex_pkg::id_ex_t i_id_ex,
    output ex_pkg::ex_mem_t      o_ex_mem
);

    logic [ex_pkg::NB_DATA-1:0] reg_a;
    logic [ex_pkg::NB_DATA-1:0] reg_b;
    ex_pkg::fwd_sel_t           fw_a;
    ex_pkg::fwd_sel_t           fw_b;
    ex_pkg::mem_wb_t            mem_wb;

    // register file reads at the decoded sources
    writeback_regfile u_writeback_regfile (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_halt   (i_halt),
        .i_ex_mem (o_ex_mem),
        .i_rs     (i_id_ex.rs),
        .i_rt     (i_id_ex.rt),
        .o_reg_a  (reg_a),
        .o_reg_b  (reg_b),
        .o_mem_wb (mem_wb)
    );

    forward_unit u_forward_unit (
        .i_rs     (i_id_ex.rs),
        .i_rt     (i_id_ex.rt),
        .i_ex_mem (o_ex_mem),
        .i_mem_wb (mem_wb),
        .o_fw_a   (fw_a),
        .o_fw_b   (fw_b)
    );

    ex_stage u_ex_stage (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_halt          (i_halt),
        .i_valid         (i_valid),
        .i_id_ex         (i_id_ex),
        .i_reg_a         (reg_a),
        .i_reg_b         (reg_b),
        .i_fw_a          (fw_a),
        .i_fw_b          (fw_b),
        .i_mem_wb_result (mem_wb.result),
        .o_ex_mem        (o_ex_mem)
    );

endmodule

`default_nettype wire

/* logic/forward_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module forward_unit (
    input  wire  [ex_pkg::NB_REG-1:0] i_rs,
    input  wire  [ex_pkg::NB_REG-1:0] i_rt,
    input  wire  ex_pkg::ex_mem_t     i_ex_mem,
    input  wire  ex_pkg::mem_wb_t     i_mem_wb,
    output ex_pkg::fwd_sel_t          o_fw_a,
    output ex_pkg::fwd_sel_t          o_fw_b
);

    // newest producer first, r0 never forwarded
    function automatic ex_pkg::fwd_sel_t pick_source(
        input logic [ex_pkg::NB_REG-1:0] src,
        input ex_pkg::ex_mem_t           ex_mem,
        input ex_pkg::mem_wb_t           mem_wb
    );
        if (ex_mem.valid && ex_mem.reg_write &&
            (ex_mem.write_reg != '0) && (ex_mem.write_reg == src)) begin
            return ex_pkg::FWD_EXMEM;
        end
        if (mem_wb.valid && mem_wb.reg_write &&
            (mem_wb.write_reg != '0) && (mem_wb.write_reg == src)) begin
            return ex_pkg::FWD_MEMWB;
        end
        return ex_pkg::FWD_REG;
    endfunction

    always_comb begin
        o_fw_a = pick_source(i_rs, i_ex_mem, i_mem_wb);
        o_fw_b = pick_source(i_rt, i_ex_mem, i_mem_wb);
    end

endmodule

`default_nettype wire

/* logic/writeback_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback_regfile (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_halt,
    input  wire  ex_pkg::ex_mem_t      i_ex_mem,
    input  wire  [ex_pkg::NB_REG-1:0]  i_rs,
    input  wire  [ex_pkg::NB_REG-1:0]  i_rt,
    output logic [ex_pkg::NB_DATA-1:0] o_reg_a,
    output logic [ex_pkg::NB_DATA-1:0] o_reg_b,
    output ex_pkg::mem_wb_t            o_mem_wb
);

    localparam int NUM_REGS = 2 ** ex_pkg::NB_REG;

    logic [ex_pkg::NB_DATA-1:0] regs [NUM_REGS];

    logic                       wb_valid_q;
    logic [ex_pkg::NB_REG-1:0]  wb_write_reg_q;
    logic                       wb_reg_write_q;
    logic [ex_pkg::NB_DATA-1:0] wb_result_q;
    logic                       wr_en;

    // mem/wb register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_valid_q     <= 1'b0;
            wb_write_reg_q <= '0;
            wb_reg_write_q <= 1'b0;
        end else if (!i_halt) begin
            wb_valid_q     <= i_ex_mem.valid;
            wb_write_reg_q <= i_ex_mem.write_reg;
            wb_reg_write_q <= i_ex_mem.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            wb_result_q <= i_ex_mem.result;
        end
    end

    // r0 is never written so it stays zero after reset
    assign wr_en = !i_halt && wb_valid_q && wb_reg_write_q && (wb_write_reg_q != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_write_reg_q] <= wb_result_q;
        end
    end

    // asynchronous read ports
    assign o_reg_a = regs[i_rs];
    assign o_reg_b = regs[i_rt];

    always_comb begin
        o_mem_wb.valid     = wb_valid_q;
        o_mem_wb.write_reg = wb_write_reg_q;
        o_mem_wb.reg_write = wb_reg_write_q;
        o_mem_wb.result    = wb_result_q;
    end

endmodule

`default_nettype wire

/* verification/tb_ex_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ex_subsystem;

    localparam int MAX_CYCLES = 600;

    logic            clk;
    logic            i_rst_n;
    logic            i_halt;
    logic            i_valid;
    ex_pkg::id_ex_t  i_id_ex;
    ex_pkg::ex_mem_t o_ex_mem;

    logic [31:0] ref_regs [32];
    int          seed = 79984;
    int          cycle_count = 0;

    ex_subsystem u_ex_subsystem (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_halt   (i_halt),
        .i_valid  (i_valid),
        .i_id_ex  (i_id_ex),
        .o_ex_mem (o_ex_mem)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // expected result from the op class rules
    function automatic logic [31:0] expected_result(input ex_pkg::id_ex_t ins,
                                                    input logic [31:0] a,
                                                    input logic [31:0] rt_val);
        logic [31:0] b;
        logic [5:0]  fn;
        logic [63:0] ext;
        b   = (ins.alu_op == ex_pkg::R_TYPE) ? rt_val : ins.immediate;
        ext = {{32{b[31]}}, b};
        fn  = ins.func;
        if (ins.alu_op == ex_pkg::LOAD_STORE) fn = ex_pkg::FN_ADD;
        if (ins.alu_op == ex_pkg::BRANCH) fn = ex_pkg::FN_IDLE;
        if (ins.alu_op == ex_pkg::I_TYPE) begin
            case (ins.opcode)
                ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU: fn = ex_pkg::FN_ADD;
                ex_pkg::OP_ANDI:  fn = ex_pkg::FN_AND;
                ex_pkg::OP_ORI:   fn = ex_pkg::FN_OR;
                ex_pkg::OP_XORI:  fn = ex_pkg::FN_XOR;
                ex_pkg::OP_SLTI:  fn = ex_pkg::FN_SLT;
                ex_pkg::OP_SLTIU: fn = ex_pkg::FN_SLTU;
                ex_pkg::OP_LUI:   fn = ex_pkg::FN_LUI;
                default:          fn = ex_pkg::FN_IDLE;
            endcase
        end
        case (fn)
            ex_pkg::FN_ADD, ex_pkg::FN_ADDU: return a + b;
            ex_pkg::FN_SUB, ex_pkg::FN_SUBU: return a - b;
            ex_pkg::FN_AND:  return a & b;
            ex_pkg::FN_OR:   return a | b;
            ex_pkg::FN_XOR:  return a ^ b;
            ex_pkg::FN_NOR:  return ~(a | b);
            ex_pkg::FN_SLT:  return {31'd0, $signed(a) < $signed(b)};
            ex_pkg::FN_SLTU: return {31'd0, a < b};
            ex_pkg::FN_SLL:  return b << ins.shamt;
            ex_pkg::FN_SRL:  return b >> ins.shamt;
            ex_pkg::FN_SRA:  return 32'(ext >> ins.shamt);
            ex_pkg::FN_SLLV: return b << a[4:0];
            ex_pkg::FN_SRLV: return b >> a[4:0];
            ex_pkg::FN_SRAV: return 32'(ext >> a[4:0]);
            ex_pkg::FN_LUI:  return {b[15:0], 16'h0000};
            default:         return 32'h0;
        endcase
    endfunction

    // code is the opcode for i-type and the function field for r-type
    function automatic ex_pkg::id_ex_t make_op(input logic [1:0] alu_op, input logic [5:0] code,
                                               input int rs, input int rt, input int rd,
                                               input logic [31:0] imm);
        ex_pkg::id_ex_t ins;
        ins           = '0;
        ins.alu_op    = alu_op;
        ins.rs        = rs;
        ins.rt        = rt;
        ins.rd        = rd;
        ins.immediate = imm;
        ins.opcode    = (alu_op == ex_pkg::R_TYPE) ? 6'b000000 : code;
        ins.func      = (alu_op == ex_pkg::R_TYPE) ? code : 6'b000000;
        ins.shamt     = imm[4:0];
        ins.reg_dst   = (alu_op == ex_pkg::R_TYPE);
        ins.imm_flag  = (alu_op == ex_pkg::I_TYPE) || (alu_op == ex_pkg::LOAD_STORE);
        ins.reg_write = (alu_op == ex_pkg::I_TYPE) || (alu_op == ex_pkg::R_TYPE);
        ins.width     = 2'b11;
        return ins;
    endfunction

    // one valid cycle and an ex/mem check after the edge
    task automatic run_instr(input ex_pkg::id_ex_t ins);
        ex_pkg::ex_mem_t exp;
        logic [31:0]     a_val;
        logic [31:0]     b_val;
        a_val         = (ins.rs == 0) ? 32'h0 : ref_regs[ins.rs];
        b_val         = (ins.rt == 0) ? 32'h0 : ref_regs[ins.rt];
        exp.valid     = 1'b1;
        exp.write_reg = ins.reg_dst ? ins.rd : ins.rt;
        exp.reg_write = ins.reg_write;
        exp.mem2reg   = ins.mem2reg;
        exp.mem_read  = ins.mem_read;
        exp.mem_write = ins.mem_write;
        exp.width     = ins.width;
        exp.sign_flag = ins.sign_flag;
        exp.result    = expected_result(ins, a_val, b_val);
        exp.data4mem  = b_val;
        if (exp.reg_write && exp.write_reg != 0) ref_regs[exp.write_reg] = exp.result;
        i_id_ex = ins;
        i_valid = 1'b1;
        @(posedge clk);
        #2;
        expect_value("o_ex_mem", o_ex_mem, exp);
        i_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic load_reg(input int r, input logic [31:0] v);
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_LUI, 0, r, 0, {16'h0, v[31:16]}));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, r, r, 0, {16'h0, v[15:0]}));
    endtask

    task automatic test_reset_state();
        expect_value("o_ex_mem.valid", o_ex_mem.valid, 0);
        expect_value("o_ex_mem.reg_write", o_ex_mem.reg_write, 0);
        expect_value("o_ex_mem.mem_read", o_ex_mem.mem_read, 0);
        expect_value("o_ex_mem.mem_write", o_ex_mem.mem_write, 0);
        expect_value("o_ex_mem.mem2reg", o_ex_mem.mem2reg, 0);
        expect_value("o_ex_mem.width", o_ex_mem.width, 3);
    endtask

    task automatic test_immediate_ops();
        logic [5:0]  ops [8];
        logic [15:0] raw;
        logic [31:0] imm;
        ops = '{ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU, ex_pkg::OP_ANDI, ex_pkg::OP_ORI,
                ex_pkg::OP_XORI, ex_pkg::OP_SLTI, ex_pkg::OP_SLTIU, ex_pkg::OP_LUI};
        for (int r = 1; r <= 3; r++) begin
            load_reg(r, $random(seed));
            idle(2);
        end
        for (int k = 0; k < 16; k++) begin
            raw = $random(seed);
            // logical ops and lui take a zero-extended immediate
            if (k / 2 inside {2, 3, 4, 7}) imm = {16'h0, raw};
            else imm = {{16{raw[15]}}, raw};
            run_instr(make_op(ex_pkg::I_TYPE, ops[k / 2], (k % 2) ? 1 + k % 3 : 0, 4 + k % 2,
                              0, imm));
            idle(2);
        end
    endtask

    task automatic test_rtype_ops();
        logic [5:0] funcs [16];
        funcs = '{ex_pkg::FN_ADD, ex_pkg::FN_ADDU, ex_pkg::FN_SUB, ex_pkg::FN_SUBU,
                  ex_pkg::FN_AND, ex_pkg::FN_OR, ex_pkg::FN_XOR, ex_pkg::FN_NOR,
                  ex_pkg::FN_SLT, ex_pkg::FN_SLTU, ex_pkg::FN_SLL, ex_pkg::FN_SRL,
                  ex_pkg::FN_SRA, ex_pkg::FN_SLLV, ex_pkg::FN_SRLV, ex_pkg::FN_SRAV};
        // negative against positive tells slt from sltu
        load_reg(1, $random(seed) | 32'h8000_0000);
        load_reg(2, $random(seed) & 32'h7fff_ffff);
        for (int k = 0; k < 32; k++) begin
            run_instr(make_op(ex_pkg::R_TYPE, funcs[k / 2], 1 + k % 2, 2 - k % 2, 24 + k % 2,
                              $random(seed)));
        end
    endtask

    task automatic test_forwarding();
        load_reg(10, $random(seed));
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_ADD, 10, 10, 11, 0));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 12, 0, $random(seed)));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 13, 0, $random(seed)));
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_ADD, 12, 12, 14, 0));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 15, 0, $random(seed)));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 16, 0, $random(seed)));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 17, 0, $random(seed)));
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_ADD, 15, 15, 18, 0));
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_SUB, 18, 16, 19, 0));
        // the newer of two r20 producers must win
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 20, 0, $random(seed)));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 20, 0, $random(seed)));
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_ADDU, 20, 0, 21, 0));
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 0, 0, $random(seed)));
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_OR, 0, 0, 22, 0));
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_OR, 0, 0, 28, 0));
    endtask

    task automatic test_load_store();
        ex_pkg::id_ex_t ins;
        load_reg(23, $random(seed));
        ins = make_op(ex_pkg::LOAD_STORE, 6'b101011, 1, 23, 0, 32'hffff_fff8);
        ins.mem_write = 1'b1;
        ins.width     = 2'b01;
        ins.sign_flag = 1'b1;
        run_instr(ins);
        ins = make_op(ex_pkg::LOAD_STORE, 6'b100011, 23, 29, 0, 32'h0000_0124);
        ins.mem_read  = 1'b1;
        ins.mem2reg   = 1'b1;
        ins.reg_write = 1'b1;
        ins.width     = 2'b10;
        run_instr(ins);
        run_instr(make_op(ex_pkg::BRANCH, 6'b000100, 1, 2, 0, 32'h0000_0010));
    endtask

    task automatic test_halt();
        ex_pkg::ex_mem_t held;
        logic [31:0]     old_r9;
        old_r9 = ref_regs[9];
        run_instr(make_op(ex_pkg::I_TYPE, ex_pkg::OP_ADDI, 0, 9, 0, $random(seed)));
        idle(1);
        // r9 sits in mem/wb waiting for its write
        i_halt  = 1'b1;
        i_valid = 1'b1;
        i_id_ex = make_op(ex_pkg::I_TYPE, ex_pkg::OP_ORI, 0, 9, 0, 32'h0000_5a5a);
        held    = o_ex_mem;
        repeat (5) begin
            @(posedge clk);
            #2;
            expect_value("o_ex_mem", o_ex_mem, held);
            expect_value("regs[9]", u_ex_subsystem.u_writeback_regfile.regs[9], old_r9);
        end
        i_halt  = 1'b0;
        i_valid = 1'b0;
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_ADDU, 9, 9, 26, 0));
        idle(2);
        expect_value("regs[9]", u_ex_subsystem.u_writeback_regfile.regs[9], ref_regs[9]);
        run_instr(make_op(ex_pkg::R_TYPE, ex_pkg::FN_SUBU, 9, 26, 27, 0));
    endtask

    initial begin
        clk     = 1'b0;
        i_rst_n = 1'b0;
        i_halt  = 1'b0;
        i_valid = 1'b0;
        i_id_ex = '0;
        for (int r = 0; r < 32; r++) ref_regs[r] = 32'h0;
        repeat (16) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        test_reset_state();
        test_immediate_ops();
        test_rtype_ops();
        test_forwarding();
        test_load_store();
        test_halt();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
